//--- dbg_harness_top.f
+incdir+source
source/dbg_harness_pkg.sv
source/dm_reg_if.sv
source/dmi_ctrl_fsm.sv
source/dm_regfile.sv
source/dbg_delay_timer.sv
source/dbg_harness_top.sv
tb/tb_dbg_harness.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dbg_harness
FILELIST  ?= dbg_harness_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_dbg_harness.sv
// one request at a time; inputs change on falling edges, every wait gives up after Timeout cycles
`timescale 1ns/10ps
`include "dbg_harness_defines.svh"

module tb_dbg_harness;
  import dbg_harness_pkg::*;

  localparam int        Timeout  = 100;
  localparam dmi_addr_t CtrlAddr = `DM_DMCONTROL_ADDR;
  localparam dmi_data_t HaltOnly = 32'h1 << `DM_HALTREQ_BIT;
  localparam dmi_data_t CtrlOnes = HaltOnly | (32'h1 << `DM_NDMRESET_BIT);

  typedef struct packed {
    logic       sel_jtag;
    dtm_op_e    op;
    dmi_addr_t  addr;
    dmi_data_t  wdata;
    dtm_resp_e  code;
    dmi_data_t  rdata;
    logic [3:0] hold;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        jtag_sel;
  logic        debug_enable;
  logic        jtag_valid;
  logic        jtag_ready;
  dmi_addr_t   jtag_addr;
  dtm_op_e     jtag_op;
  dmi_data_t   jtag_data;
  logic        jtag_rvalid;
  logic        jtag_rready;
  logic        dtm_valid;
  logic        dtm_ready;
  dmi_addr_t   dtm_addr;
  dtm_op_e     dtm_op;
  dmi_data_t   dtm_data;
  logic        dtm_rvalid;
  logic        dtm_rready;
  dmi_data_t   resp_data;
  dtm_resp_e   resp_code;
  logic        debug_req;
  logic        ndmreset;
  int          n_mismatch = 0;
  int          n_timeout  = 0;
  int          cyc        = 0;
  logic [31:0] lfsr;
  dmi_data_t   words [`DM_NUM_WORDS];
  entry_t      tbl [$];

  dbg_harness_top dut0 (
    .clk_i             ( clk          ),
    .rst_ni            ( rst_n        ),
    .jtag_sel_i        ( jtag_sel     ),
    .jtag_req_valid_i  ( jtag_valid   ),
    .jtag_req_ready_o  ( jtag_ready   ),
    .jtag_req_addr_i   ( jtag_addr    ),
    .jtag_req_op_i     ( jtag_op      ),
    .jtag_req_data_i   ( jtag_data    ),
    .jtag_resp_valid_o ( jtag_rvalid  ),
    .jtag_resp_ready_i ( jtag_rready  ),
    .dtm_req_valid_i   ( dtm_valid    ),
    .dtm_req_ready_o   ( dtm_ready    ),
    .dtm_req_addr_i    ( dtm_addr     ),
    .dtm_req_op_i      ( dtm_op       ),
    .dtm_req_data_i    ( dtm_data     ),
    .dtm_resp_valid_o  ( dtm_rvalid   ),
    .dtm_resp_ready_i  ( dtm_rready   ),
    .resp_data_o       ( resp_data    ),
    .resp_code_o       ( resp_code    ),
    .debug_enable_i    ( debug_enable ),
    .debug_req_o       ( debug_req    ),
    .ndmreset_o        ( ndmreset     )
  );

  always #5 clk = ~clk;

  // edges since reset release
  always @(posedge clk) begin
    cyc <= rst_n ? cyc + 1 : 0;
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, exp);
      n_mismatch++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout: %s", what);
    n_timeout++;
    jtag_valid = 1'b0;
    dtm_valid  = 1'b0;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic dmi_data_t lfsr_word();
    dmi_data_t w;
    logic      fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      w    = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic entry_t make_entry(input logic sel_jtag, input dtm_op_e op,
      input dmi_addr_t addr, input dmi_data_t wdata, input dtm_resp_e code,
      input dmi_data_t rdata, input logic [3:0] hold);
    return '{sel_jtag, op, addr, wdata, code, rdata, hold};
  endfunction

  function automatic logic sel_ready(input logic sel_jtag);
    return sel_jtag ? jtag_ready : dtm_ready;
  endfunction

  function automatic logic sel_rvalid(input logic sel_jtag);
    return sel_jtag ? jtag_rvalid : dtm_rvalid;
  endfunction

  // the source that is not selected must see nothing
  task automatic check_quiet(input logic sel_jtag);
    if (sel_jtag) begin
      check("dtm_req_ready_o", dtm_ready, 1'b0);
      check("dtm_resp_valid_o", dtm_rvalid, 1'b0);
    end else begin
      check("jtag_req_ready_o", jtag_ready, 1'b0);
      check("jtag_resp_valid_o", jtag_rvalid, 1'b0);
    end
  endtask

  // ------------------------------------------------------------------------
  // one request, with the other source pushing a stray write meanwhile
  // ------------------------------------------------------------------------
  task automatic run_entry(input entry_t e);
    int        t;
    dmi_data_t held;
    @(negedge clk);
    jtag_sel = e.sel_jtag;
    @(negedge clk);
    jtag_valid  = 1'b1;
    dtm_valid   = 1'b1;
    jtag_op     = e.sel_jtag ? e.op : DTM_WRITE;
    jtag_addr   = e.sel_jtag ? e.addr : '0;
    jtag_data   = e.sel_jtag ? e.wdata : 32'hdead_beef;
    dtm_op      = e.sel_jtag ? DTM_WRITE : e.op;
    dtm_addr    = e.sel_jtag ? '0 : e.addr;
    dtm_data    = e.sel_jtag ? 32'hdead_beef : e.wdata;
    jtag_rready = (e.hold == 4'd0);
    dtm_rready  = (e.hold == 4'd0);
    t = 0;
    while (!sel_ready(e.sel_jtag) && t < Timeout) begin
      check_quiet(e.sel_jtag);
      @(negedge clk);
      t++;
    end
    if (t >= Timeout) begin
      note_timeout("request was never accepted");
      return;
    end
    // idle with the selected source ready
    check_quiet(e.sel_jtag);
    @(negedge clk);
    if (e.sel_jtag) begin
      jtag_valid = 1'b0;
    end else begin
      dtm_valid = 1'b0;
    end
    t = 0;
    while (!sel_rvalid(e.sel_jtag) && t < Timeout) begin
      check_quiet(e.sel_jtag);
      @(negedge clk);
      t++;
    end
    if (t >= Timeout) begin
      note_timeout("no response arrived");
      return;
    end
    check_quiet(e.sel_jtag);
    held = resp_data;
    for (int i = 0; i < int'(e.hold); i++) begin
      @(negedge clk);
      check_quiet(e.sel_jtag);
      check("resp_valid_o", sel_rvalid(e.sel_jtag), 1'b1);
      check("resp_data_o", resp_data, held);
    end
    jtag_rready = 1'b1;
    dtm_rready  = 1'b1;
    check("resp_code_o", resp_code, e.code);
    check("resp_data_o", resp_data, e.rdata);
    @(negedge clk);
    check("resp_valid_o", sel_rvalid(e.sel_jtag), 1'b0);
    jtag_valid = 1'b0;
    dtm_valid  = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    int t;
    lfsr         = 32'h59302e54;
    rst_n        = 1'b0;
    jtag_sel     = 1'b1;
    debug_enable = 1'b1;
    jtag_valid   = 1'b0;
    jtag_op      = DTM_NOP;
    jtag_addr    = '0;
    jtag_data    = '0;
    jtag_rready  = 1'b1;
    dtm_valid    = 1'b0;
    dtm_op       = DTM_NOP;
    dtm_addr     = '0;
    dtm_data     = '0;
    dtm_rready   = 1'b1;

    // written through one source, read back through the other
    for (int i = 0; i < `DM_NUM_WORDS; i++) begin
      words[i] = lfsr_word();
      tbl.push_back(make_entry(i[0], DTM_WRITE, dmi_addr_t'(i), words[i], DTM_OK, '0, 4'd0));
    end
    for (int i = 0; i < `DM_NUM_WORDS; i++) begin
      tbl.push_back(make_entry(!i[0], DTM_READ, dmi_addr_t'(i), '0, DTM_OK, words[i], 4'd0));
    end
    tbl.push_back(make_entry(1'b1, DTM_READ, 7'd40, '0, DTM_ERR, '0, 4'd0));
    tbl.push_back(make_entry(1'b0, DTM_WRITE, 7'd40, lfsr_word(), DTM_ERR, '0, 4'd0));
    tbl.push_back(make_entry(1'b1, DTM_RSVD, 7'd5, lfsr_word(), DTM_ERR, '0, 4'd0));
    // nop must leave word 3 alone
    tbl.push_back(make_entry(1'b0, DTM_NOP, 7'd3, '1, DTM_OK, '0, 4'd0));
    tbl.push_back(make_entry(1'b1, DTM_READ, 7'd3, '0, DTM_OK, words[3], 4'd0));
    tbl.push_back(make_entry(1'b0, DTM_WRITE, CtrlAddr, '1, DTM_OK, '0, 4'd0));
    tbl.push_back(make_entry(1'b1, DTM_READ, CtrlAddr, '0, DTM_OK, CtrlOnes, 4'd0));
    // response held back by the source
    tbl.push_back(make_entry(1'b0, DTM_READ, 7'd9, '0, DTM_OK, words[9], 4'd6));

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check("ndmreset_o", ndmreset, 1'b0);
    check("debug_req_o", debug_req, 1'b0);

    // haltreq inside the delay window stays away from the core
    run_entry(make_entry(1'b1, DTM_WRITE, CtrlAddr, HaltOnly, DTM_OK, '0, 4'd0));
    check("debug_req_o", debug_req, 1'b0);
    t = 0;
    while (!debug_req && t < Timeout) begin
      @(negedge clk);
      t++;
    end
    if (t >= Timeout) begin
      note_timeout("debug_req_o never rose after the delay window");
    end
    check("delay window passed", cyc >= `DM_DELAY_CYCLES, 1'b1);
    debug_enable = 1'b0;
    @(negedge clk);
    check("debug_req_o", debug_req, 1'b0);
    debug_enable = 1'b1;
    @(negedge clk);
    check("debug_req_o", debug_req, 1'b1);

    foreach (tbl[i]) begin
      run_entry(tbl[i]);
    end
    check("ndmreset_o", ndmreset, 1'b1);
    run_entry(make_entry(1'b0, DTM_WRITE, CtrlAddr, '0, DTM_OK, '0, 4'd0));
    check("ndmreset_o", ndmreset, 1'b0);

    $display("errors: %0d mismatches, %0d timeouts", n_mismatch, n_timeout);
    if (n_mismatch == 0 && n_timeout == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- source/dbg_harness_top.sv
// two DMI sources, jtag_sel_i picks which one is served; keep it stable while a request is open
`timescale 1ns/10ps

module dbg_harness_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       jtag_sel_i,
  // JTAG-side source
  input  logic                       jtag_req_valid_i,
  output logic                       jtag_req_ready_o,
  input  dbg_harness_pkg::dmi_addr_t jtag_req_addr_i,
  input  dbg_harness_pkg::dtm_op_e   jtag_req_op_i,
  input  dbg_harness_pkg::dmi_data_t jtag_req_data_i,
  output logic                       jtag_resp_valid_o,
  input  logic                       jtag_resp_ready_i,
  // DTM-side source
  input  logic                       dtm_req_valid_i,
  output logic                       dtm_req_ready_o,
  input  dbg_harness_pkg::dmi_addr_t dtm_req_addr_i,
  input  dbg_harness_pkg::dtm_op_e   dtm_req_op_i,
  input  dbg_harness_pkg::dmi_data_t dtm_req_data_i,
  output logic                       dtm_resp_valid_o,
  input  logic                       dtm_resp_ready_i,
  // shared response payload
  output dbg_harness_pkg::dmi_data_t resp_data_o,
  output dbg_harness_pkg::dtm_resp_e resp_code_o,
  // core side
  input  logic                       debug_enable_i,
  output logic                       debug_req_o,
  output logic                       ndmreset_o
);

  logic haltreq;

  dm_reg_if reg_if ();

  // ------------------------------------------------------------------------
  // DMI controller
  // ------------------------------------------------------------------------
  dmi_ctrl_fsm i_dmi_ctrl_fsm (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .jtag_sel_i        ( jtag_sel_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_req_addr_i   ( jtag_req_addr_i   ),
    .jtag_req_op_i     ( jtag_req_op_i     ),
    .jtag_req_data_i   ( jtag_req_data_i   ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_req_addr_i    ( dtm_req_addr_i    ),
    .dtm_req_op_i      ( dtm_req_op_i      ),
    .dtm_req_data_i    ( dtm_req_data_i    ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .resp_data_o       ( resp_data_o       ),
    .resp_code_o       ( resp_code_o       ),
    .reg_o             ( reg_if.fsm        )
  );

  // ------------------------------------------------------------------------
  // register space
  // ------------------------------------------------------------------------
  dm_regfile i_dm_regfile (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .reg_i      ( reg_if.regs ),
    .haltreq_o  ( haltreq     ),
    .ndmreset_o ( ndmreset_o  )
  );

  // ------------------------------------------------------------------------
  // core debug request gate
  // ------------------------------------------------------------------------
  dbg_delay_timer i_dbg_delay_timer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .haltreq_i      ( haltreq        ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

//--- source/dbg_delay_timer.sv
// debug request blocked for DM_DELAY_CYCLES edges after reset release and while debug is disabled
`timescale 1ns/10ps
`include "dbg_harness_defines.svh"

module dbg_delay_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic haltreq_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  localparam int unsigned CntW = $clog2(`DM_DELAY_CYCLES + 1);
  localparam logic [CntW-1:0] CntLoad = CntW'(`DM_DELAY_CYCLES);

  logic [CntW-1:0] cnt_q;
  logic            cnt_done;

  assign cnt_done = (cnt_q == '0);

  // down-counter, parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntLoad;
    end else if (!cnt_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // window lets the core run its boot code before it can be halted
  assign debug_req_o = cnt_done && debug_enable_i && haltreq_i;

  a_cnt_monotonic : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= $past(cnt_q));

endmodule

//--- source/dm_regfile.sv
// one-cycle read latency; write responses carry zero data, unmapped addresses flag err
`timescale 1ns/10ps
`include "dbg_harness_defines.svh"

module dm_regfile (
  input  logic    clk_i,
  input  logic    rst_ni,
  dm_reg_if.regs  reg_i,
  output logic    haltreq_o,
  output logic    ndmreset_o
);
  import dbg_harness_pkg::*;

  localparam int unsigned IdxW = $clog2(`DM_NUM_WORDS);

  dmi_data_t mem_q [`DM_NUM_WORDS];
  logic      haltreq_q;
  logic      ndmreset_q;
  dmi_data_t rdata_q;
  logic      err_q;

  logic      hit_word;
  logic      hit_ctrl;
  logic      [IdxW-1:0] idx;
  dmi_data_t ctrl_word;
  dmi_data_t read_val;

  // ------------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------------
  assign hit_word = (reg_i.addr < `DM_NUM_WORDS);
  assign hit_ctrl = (reg_i.addr == `DM_DMCONTROL_ADDR);
  assign idx      = reg_i.addr[IdxW-1:0];

  // dmcontrol as seen by a read, fields in place
  always_comb begin
    ctrl_word                   = '0;
    ctrl_word[`DM_HALTREQ_BIT]  = haltreq_q;
    ctrl_word[`DM_NDMRESET_BIT] = ndmreset_q;
  end

  always_comb begin
    if (hit_word) begin
      read_val = mem_q[idx];
    end else if (hit_ctrl) begin
      read_val = ctrl_word;
    end else begin
      read_val = '0;
    end
  end

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `DM_NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
      haltreq_q  <= 1'b0;
      ndmreset_q <= 1'b0;
      err_q      <= 1'b0;
    end else if (reg_i.req) begin
      err_q <= !(hit_word || hit_ctrl);
      if (reg_i.we && hit_word) begin
        mem_q[idx] <= reg_i.wdata;
      end
      if (reg_i.we && hit_ctrl) begin
        haltreq_q  <= reg_i.wdata[`DM_HALTREQ_BIT];
        ndmreset_q <= reg_i.wdata[`DM_NDMRESET_BIT];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_i.req) begin
      rdata_q <= reg_i.we ? '0 : read_val;
    end
  end

  assign reg_i.rdata = rdata_q;
  assign reg_i.err   = err_q;
  assign haltreq_o   = haltreq_q;
  assign ndmreset_o  = ndmreset_q;

  a_unmapped_err : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (reg_i.req && !(hit_word || hit_ctrl)) |=> (reg_i.err && (reg_i.rdata == '0)));

endmodule

//--- source/dmi_ctrl_fsm.sv
// one DMI request in flight; the response goes only to the source latched at accept
`timescale 1ns/10ps

module dmi_ctrl_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       jtag_sel_i,
  // JTAG-side source
  input  logic                       jtag_req_valid_i,
  output logic                       jtag_req_ready_o,
  input  dbg_harness_pkg::dmi_addr_t jtag_req_addr_i,
  input  dbg_harness_pkg::dtm_op_e   jtag_req_op_i,
  input  dbg_harness_pkg::dmi_data_t jtag_req_data_i,
  output logic                       jtag_resp_valid_o,
  input  logic                       jtag_resp_ready_i,
  // DTM-side source
  input  logic                       dtm_req_valid_i,
  output logic                       dtm_req_ready_o,
  input  dbg_harness_pkg::dmi_addr_t dtm_req_addr_i,
  input  dbg_harness_pkg::dtm_op_e   dtm_req_op_i,
  input  dbg_harness_pkg::dmi_data_t dtm_req_data_i,
  output logic                       dtm_resp_valid_o,
  input  logic                       dtm_resp_ready_i,
  // shared response payload
  output dbg_harness_pkg::dmi_data_t resp_data_o,
  output dbg_harness_pkg::dtm_resp_e resp_code_o,
  dm_reg_if.fsm                      reg_o
);
  import dbg_harness_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESP
  } state_e;

  state_e    state_q;
  state_e    state_d;
  logic      ready_en_q;
  logic      src_jtag_q;
  dtm_op_e   op_q;
  dmi_addr_t addr_q;
  dmi_data_t data_q;

  logic      sel_valid;
  logic      accept;
  logic      resp_ready;
  logic      reg_op;

  // ------------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------------
  assign sel_valid = jtag_sel_i ? jtag_req_valid_i : dtm_req_valid_i;

  // ready held off for the first cycle out of reset
  assign jtag_req_ready_o = ready_en_q && (state_q == IDLE) && jtag_sel_i;
  assign dtm_req_ready_o  = ready_en_q && (state_q == IDLE) && !jtag_sel_i;

  assign accept     = (jtag_req_ready_o || dtm_req_ready_o) && sel_valid;
  assign resp_ready = src_jtag_q ? jtag_resp_ready_i : dtm_resp_ready_i;
  assign reg_op     = (op_q == DTM_READ) || (op_q == DTM_WRITE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = ACCESS;
        end
      end
      ACCESS: state_d = RESP;
      RESP: begin
        if (resp_ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      ready_en_q <= 1'b0;
      src_jtag_q <= 1'b0;
      op_q       <= DTM_NOP;
    end else begin
      state_q    <= state_d;
      ready_en_q <= 1'b1;
      if (accept) begin
        src_jtag_q <= jtag_sel_i;
        op_q       <= jtag_sel_i ? jtag_req_op_i : dtm_req_op_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= jtag_sel_i ? jtag_req_addr_i : dtm_req_addr_i;
      data_q <= jtag_sel_i ? jtag_req_data_i : dtm_req_data_i;
    end
  end

  // ------------------------------------------------------------------------
  // register access, one strobe per read or write
  // ------------------------------------------------------------------------
  assign reg_o.req   = (state_q == ACCESS) && reg_op;
  assign reg_o.we    = (op_q == DTM_WRITE);
  assign reg_o.addr  = addr_q;
  assign reg_o.wdata = data_q;

  // ------------------------------------------------------------------------
  // response side
  // ------------------------------------------------------------------------
  assign jtag_resp_valid_o = (state_q == RESP) && src_jtag_q;
  assign dtm_resp_valid_o  = (state_q == RESP) && !src_jtag_q;

  // nop and reserved ops are answered here without touching the registers
  always_comb begin
    if (reg_op) begin
      resp_data_o = reg_o.rdata;
      resp_code_o = reg_o.err ? DTM_ERR : DTM_OK;
    end else begin
      resp_data_o = '0;
      resp_code_o = (op_q == DTM_RSVD) ? DTM_ERR : DTM_OK;
    end
  end

  a_no_ready_during_resp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((jtag_req_ready_o || dtm_req_ready_o) && (jtag_resp_valid_o || dtm_resp_valid_o)));

  a_req_single_cycle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_o.req |=> !reg_o.req);

endmodule

//--- source/dm_reg_if.sv
// controller to register file link; req is a single-cycle strobe, rdata/err valid one cycle later
`timescale 1ns/10ps

interface dm_reg_if;
  import dbg_harness_pkg::*;

  // request side, driven by the controller
  logic      req;
  logic      we;
  dmi_addr_t addr;
  dmi_data_t wdata;

  // result side, held until the next req
  dmi_data_t rdata;
  logic      err;

  modport fsm (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata,
    input  err
  );

  modport regs (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata,
    output err
  );

endinterface

//--- source/dbg_harness_pkg.sv
// DMI address/data types and opcode/response encodings; widths come from the defines header
`include "dbg_harness_defines.svh"

package dbg_harness_pkg;

  // ------------------------------------------------------------------------
  // DMI payload types
  // ------------------------------------------------------------------------
  typedef logic [`DM_ADDR_W-1:0] dmi_addr_t;
  typedef logic [`DM_DATA_W-1:0] dmi_data_t;

  // ------------------------------------------------------------------------
  // DMI encodings
  // ------------------------------------------------------------------------
  // request opcode, as carried on req_op
  typedef enum logic [1:0] {
    DTM_NOP   = 2'd0,
    DTM_READ  = 2'd1,
    DTM_WRITE = 2'd2,
    DTM_RSVD  = 2'd3
  } dtm_op_e;

  // response code, value 1 is not used
  typedef enum logic [1:0] {
    DTM_OK  = 2'd0,
    DTM_ERR = 2'd2
  } dtm_resp_e;

endpackage

//--- source/dbg_harness_defines.svh
// widths and register map of the debug front end; the delay window is shortened for simulation
`ifndef DBG_HARNESS_DEFINES_SVH
`define DBG_HARNESS_DEFINES_SVH

// ------------------------------------------------------------------------
// DMI widths
// ------------------------------------------------------------------------
`define DM_ADDR_W 7
`define DM_DATA_W 32

// ------------------------------------------------------------------------
// register map
// ------------------------------------------------------------------------
// data words sit at addresses 0 .. DM_NUM_WORDS-1
`define DM_NUM_WORDS 16
`define DM_DMCONTROL_ADDR 16

// dmcontrol fields, all other bits read as zero
`define DM_HALTREQ_BIT 31
`define DM_NDMRESET_BIT 1

// ------------------------------------------------------------------------
// debug request gate
// ------------------------------------------------------------------------
// cycles after reset release before a debug request may reach the core.
// any positive value works
`define DM_DELAY_CYCLES 32

`endif
